/* hdl/mem_stage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Data memory geometry
`define MEM_DEPTH_WORDS 1024
`define NUM_LANES 4

// Writable I/O registers, all other I/O addresses are read only
`define IO_UART_TX_ADDR 32'h8000_0008
`define IO_LED_ADDR 32'h8000_0018

`endif

/* hdl/mem_pkg.sv */
`include "mem_stage_config.svh"

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;
    typedef logic [$clog2(`MEM_DEPTH_WORDS)-1:0] lane_idx_t;

    // Instruction bits 6 to 2
    typedef logic [4:0] opcode5_t;
    typedef logic [2:0] funct3_t;

    localparam opcode5_t OPC_LUI_5 = 5'b01101;
    localparam opcode5_t OPC_AUIPC_5 = 5'b00101;
    localparam opcode5_t OPC_JAL_5 = 5'b11011;
    localparam opcode5_t OPC_JALR_5 = 5'b11001;
    localparam opcode5_t OPC_BRANCH_5 = 5'b11000;
    localparam opcode5_t OPC_STORE_5 = 5'b01000;
    localparam opcode5_t OPC_LOAD_5 = 5'b00000;
    localparam opcode5_t OPC_ARI_RTYPE_5 = 5'b01100;
    localparam opcode5_t OPC_ARI_ITYPE_5 = 5'b00100;

    // Loads
    localparam funct3_t FNC_LB = 3'b000;
    localparam funct3_t FNC_LH = 3'b001;
    localparam funct3_t FNC_LW = 3'b010;
    localparam funct3_t FNC_LBU = 3'b100;
    localparam funct3_t FNC_LHU = 3'b101;

    // Stores
    localparam funct3_t FNC_SB = 3'b000;
    localparam funct3_t FNC_SH = 3'b001;
    localparam funct3_t FNC_SW = 3'b010;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_e;

endpackage

/* hdl/lane_if.sv */
`timescale 1ns/1ns

interface lane_if;
    import mem_pkg::*;

    logic we;
    lane_idx_t idx;
    byte_t wdata;
    byte_t rdata;

    // Decode side
    modport ctrl (
        output we,
        output idx,
        output wdata
    );

    // RAM lane itself
    modport mem (
        input  we,
        input  idx,
        input  wdata,
        output rdata
    );

    // Read data only, for load alignment
    modport monitor (
        input rdata
    );

endinterface

/* hdl/mem_control.sv */
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module mem_control (
    input  mem_pkg::word_t        inst,
    input  mem_pkg::word_t        pc,
    input  mem_pkg::word_t        addr,
    input  mem_pkg::word_t        st_data,
    lane_if.ctrl                  lanes [`NUM_LANES],
    output mem_pkg::access_size_e ld_size,
    output logic                  ld_unsigned,
    output logic                  is_load,
    output logic                  imem_we,
    output logic                  io_we,
    output mem_pkg::word_t        io_wdata
);
    import mem_pkg::*;

    localparam int IDX_W = $bits(lane_idx_t);

    opcode5_t opcode5;
    funct3_t funct3;
    logic [1:0] offset;
    logic is_store;
    logic dmem_write;
    access_size_e size;
    logic [`NUM_LANES-1:0] size_mask;
    logic [`NUM_LANES-1:0] we_vec;
    word_t wdata_shift;
    lane_idx_t idx;

    assign opcode5 = inst[6:2];
    assign funct3 = inst[14:12];
    assign offset = addr[1:0];
    assign idx = addr[IDX_W+1:2];

    always_comb begin
        is_load = 1'b0;
        is_store = 1'b0;
        size = SIZE_WORD;
        ld_unsigned = 1'b0;
        case (opcode5)
            OPC_LOAD_5: begin
                is_load = 1'b1;
                case (funct3)
                    FNC_LB: size = SIZE_BYTE;
                    FNC_LH: size = SIZE_HALF;
                    FNC_LW: size = SIZE_WORD;
                    FNC_LBU: begin
                        size = SIZE_BYTE;
                        ld_unsigned = 1'b1;
                    end
                    FNC_LHU: begin
                        size = SIZE_HALF;
                        ld_unsigned = 1'b1;
                    end
                    default: is_load = 1'b0;
                endcase
            end
            OPC_STORE_5: begin
                is_store = 1'b1;
                case (funct3)
                    FNC_SB: size = SIZE_BYTE;
                    FNC_SH: size = SIZE_HALF;
                    FNC_SW: size = SIZE_WORD;
                    default: is_store = 1'b0;
                endcase
            end
            OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5, OPC_BRANCH_5,
            OPC_JAL_5, OPC_JALR_5, OPC_LUI_5, OPC_AUIPC_5: begin
                // ALU, branch and jump instructions touch no memory
            end
            default: begin
                // Unknown opcodes behave as no-ops here
            end
        endcase
    end

    assign ld_size = size;

    // Lane pattern before shifting by the byte offset
    always_comb begin
        size_mask = '0;
        case (size)
            SIZE_BYTE: size_mask[0] = 1'b1;
            SIZE_HALF: size_mask[1:0] = 2'b11;
            default: size_mask = '1;
        endcase
    end

    // BIOS mode redirects stores to the instruction memory
    assign dmem_write = is_store && !addr[31] && !pc[30];
    assign we_vec = dmem_write ? (size_mask << offset) : '0;
    assign wdata_shift = st_data << {offset, 3'b000};

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        assign lanes[g].we = we_vec[g];
        assign lanes[g].idx = idx;
        assign lanes[g].wdata = wdata_shift[8*g +: 8];
    end

    assign imem_we = is_store && pc[30];
    assign io_we = is_store && (addr == `IO_UART_TX_ADDR || addr == `IO_LED_ADDR);
    assign io_wdata = st_data;

    always_comb begin
        if (is_load || is_store) begin
            a_aligned: assert final (!(size == SIZE_HALF && offset[0])
                                     && !(size == SIZE_WORD && offset != 2'b00))
                else $error("misaligned access to %h", addr);
        end
    end

endmodule

/* hdl/dmem_lane.sv */
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module dmem_lane (
    input logic  clk,
    lane_if.mem  port
);
    import mem_pkg::*;

    byte_t mem [`MEM_DEPTH_WORDS];

    // Read before write, a store is seen by the next cycle's load
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.idx] <= port.wdata;
        end
        port.rdata <= mem[port.idx];
    end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module load_align (
    input  logic                  clk,
    input  logic                  arst_n,
    lane_if.monitor               lanes [`NUM_LANES],
    input  logic                  is_load,
    input  mem_pkg::access_size_e ld_size,
    input  logic                  ld_unsigned,
    input  mem_pkg::word_t        addr,
    input  mem_pkg::word_t        io_rdata,
    output mem_pkg::word_t        ld_data
);
    import mem_pkg::*;

    logic load_q;
    access_size_e size_q;
    logic unsigned_q;
    logic [1:0] offset_q;
    logic io_q;
    word_t rword;
    word_t shifted;

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_gather
        assign rword[8*g +: 8] = lanes[g].rdata;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q <= 1'b0;
            size_q <= SIZE_WORD;
            unsigned_q <= 1'b0;
            offset_q <= 2'b00;
            io_q <= 1'b0;
        end else begin
            load_q <= is_load;
            size_q <= ld_size;
            unsigned_q <= ld_unsigned;
            offset_q <= addr[1:0];
            io_q <= addr[31];
        end
    end

    // Addressed byte or halfword down to bit 0
    assign shifted = rword >> {offset_q, 3'b000};

    always_comb begin
        ld_data = '0;
        if (load_q) begin
            if (io_q) begin
                ld_data = io_rdata;
            end else begin
                case (size_q)
                    SIZE_BYTE: begin
                        if (unsigned_q) begin
                            ld_data = {24'b0, shifted[7:0]};
                        end else begin
                            ld_data = {{24{shifted[7]}}, shifted[7:0]};
                        end
                    end
                    SIZE_HALF: begin
                        if (unsigned_q) begin
                            ld_data = {16'b0, shifted[15:0]};
                        end else begin
                            ld_data = {{16{shifted[15]}}, shifted[15:0]};
                        end
                    end
                    default: ld_data = shifted;
                endcase
            end
        end
    end

    a_word_offset: assert property (@(posedge clk) disable iff (!arst_n)
        (load_q && size_q == SIZE_WORD) |-> offset_q == 2'b00)
        else $error("word load registered with offset %0d", offset_q);

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module mem_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  mem_pkg::word_t inst,
    input  mem_pkg::word_t pc,
    input  mem_pkg::word_t addr,
    input  mem_pkg::word_t st_data,
    input  mem_pkg::word_t io_rdata,
    output mem_pkg::word_t ld_data,
    output logic           imem_we,
    output logic           io_we,
    output mem_pkg::word_t io_wdata
);
    import mem_pkg::*;

    lane_if lanes [`NUM_LANES] ();

    access_size_e ld_size;
    logic ld_unsigned;
    logic is_load;

    mem_control i_mem_control (
        .inst        (inst),
        .pc          (pc),
        .addr        (addr),
        .st_data     (st_data),
        .lanes       (lanes),
        .ld_size     (ld_size),
        .ld_unsigned (ld_unsigned),
        .is_load     (is_load),
        .imem_we     (imem_we),
        .io_we       (io_we),
        .io_wdata    (io_wdata)
    );

    // One byte-wide RAM per lane
    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        dmem_lane i_dmem_lane (
            .clk  (clk),
            .port (lanes[g])
        );
    end

    load_align i_load_align (
        .clk         (clk),
        .arst_n      (arst_n),
        .lanes       (lanes),
        .is_load     (is_load),
        .ld_size     (ld_size),
        .ld_unsigned (ld_unsigned),
        .addr        (addr),
        .io_rdata    (io_rdata),
        .ld_data     (ld_data)
    );

endmodule

/* verif/tb_mem_stage.sv */
`timescale 1ns/1ns
`include "mem_stage_config.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int RESET_CYCLES = 2;

    typedef struct {
        word_t inst;
        word_t pc;
        word_t addr;
        word_t st_data;
        word_t io_next;
        word_t exp_ld;
        logic  exp_imem;
        logic  exp_io;
    } row_t;

    logic clk;
    logic arst_n;
    word_t inst;
    word_t pc;
    word_t addr;
    word_t st_data;
    word_t io_rdata;
    word_t ld_data;
    logic imem_we;
    logic io_we;
    word_t io_wdata;

    row_t rows[$];
    int errors = 0;
    int cycles = 0;
    int timeout_limit = 0;

    mem_stage i_mem_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst     (inst),
        .pc       (pc),
        .addr     (addr),
        .st_data  (st_data),
        .io_rdata (io_rdata),
        .ld_data  (ld_data),
        .imem_we  (imem_we),
        .io_we    (io_we),
        .io_wdata (io_wdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Only opcode and funct3 matter to the stage
    function automatic word_t make_inst(input opcode5_t op5, input funct3_t f3);
        return {17'b0, f3, 5'b0, op5, 2'b11};
    endfunction

    task automatic add_row(input word_t r_inst, input word_t r_pc, input word_t r_addr,
                           input word_t r_st_data, input word_t r_io_next,
                           input word_t r_exp_ld, input logic r_exp_imem,
                           input logic r_exp_io);
        row_t r;
        r.inst = r_inst;
        r.pc = r_pc;
        r.addr = r_addr;
        r.st_data = r_st_data;
        r.io_next = r_io_next;
        r.exp_ld = r_exp_ld;
        r.exp_imem = r_exp_imem;
        r.exp_io = r_exp_io;
        rows.push_back(r);
    endtask

    // exp_ld is the load result of the row before
    task automatic build_table();
        word_t add_i;
        word_t beq_i;
        add_i = make_inst(OPC_ARI_RTYPE_5, 3'b000);
        beq_i = make_inst(OPC_BRANCH_5, 3'b000);
        add_row(add_i, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_STORE_5, FNC_SW), 32'h0, 32'h100, 32'h8765_4321, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h100, 32'h0, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_STORE_5, FNC_SB), 32'h0, 32'h101, 32'h0000_00aa, 32'h0,
                32'h8765_4321, 1'b0, 1'b0);
        add_row(make_inst(OPC_STORE_5, FNC_SH), 32'h0, 32'h102, 32'h0000_beef, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h100, 32'h0, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LB), 32'h0, 32'h101, 32'h0, 32'h0,
                32'hbeef_aa21, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LBU), 32'h0, 32'h101, 32'h0, 32'h0,
                32'hffff_ffaa, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LH), 32'h0, 32'h102, 32'h0, 32'h0,
                32'h0000_00aa, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LHU), 32'h0, 32'h102, 32'h0, 32'h0,
                32'hffff_beef, 1'b0, 1'b0);
        // Store to the UART TX register leaves memory unchanged
        add_row(make_inst(OPC_STORE_5, FNC_SW), 32'h0, `IO_UART_TX_ADDR, 32'h1234_5678,
                32'h0, 32'h0000_beef, 1'b0, 1'b1);
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h100, 32'h0, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h8000_0010, 32'h0, 32'hcafe_0042,
                32'hbeef_aa21, 1'b0, 1'b0);
        add_row(add_i, 32'h0, 32'h0, 32'h0, 32'h0, 32'hcafe_0042, 1'b0, 1'b0);
        // BIOS mode store goes to instruction memory only
        add_row(make_inst(OPC_STORE_5, FNC_SW), 32'h4000_0000, 32'h100, 32'hdead_beef,
                32'h0, 32'h0, 1'b1, 1'b0);
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h100, 32'h0, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(beq_i, 32'h0, 32'h100, 32'h5555_5555, 32'h0, 32'hbeef_aa21, 1'b0, 1'b0);
        // Branch row must not have touched the word
        add_row(make_inst(OPC_LOAD_5, FNC_LW), 32'h0, 32'h100, 32'h0, 32'h0,
                32'h0, 1'b0, 1'b0);
        add_row(make_inst(OPC_STORE_5, FNC_SB), 32'h0, `IO_LED_ADDR, 32'h0000_005a, 32'h0,
                32'hbeef_aa21, 1'b0, 1'b1);
        add_row(add_i, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic apply_row(input int i);
        inst = rows[i].inst;
        pc = rows[i].pc;
        addr = rows[i].addr;
        st_data = rows[i].st_data;
        // I/O read value belongs to the previous row's load
        io_rdata = (i > 0) ? rows[i-1].io_next : 32'h0;
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = rows[i];
        assert (imem_we === r.exp_imem) else begin
            errors++;
            $display("FAIL row %0d imem_we expected %h actual %h", i, r.exp_imem, imem_we);
        end
        assert (io_we === r.exp_io) else begin
            errors++;
            $display("FAIL row %0d io_we expected %h actual %h", i, r.exp_io, io_we);
        end
        if (r.exp_io) begin
            assert (io_wdata === r.st_data) else begin
                errors++;
                $display("FAIL row %0d io_wdata expected %h actual %h", i, r.st_data,
                         io_wdata);
            end
        end
        assert (ld_data === r.exp_ld) else begin
            errors++;
            $display("FAIL row %0d ld_data expected %h actual %h", i, r.exp_ld, ld_data);
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        inst = make_inst(OPC_ARI_ITYPE_5, 3'b000);
        pc = 32'h0;
        addr = 32'h0;
        st_data = 32'h0;
        io_rdata = 32'h0;
        build_table();
        timeout_limit = rows.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Check 1 ns before the rising edge once inputs have settled
        foreach (rows[i]) begin
            apply_row(i);
            #1;
            check_row(i);
            @(negedge clk);
        end

        $display("Checked %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/lane_if.sv
hdl/mem_control.sv
hdl/dmem_lane.sv
hdl/load_align.sv
hdl/mem_stage.sv
verif/tb_mem_stage.sv

/* run.sh */
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ns \
    --top-module tb_mem_stage -Mdir obj_dir -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_stage)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
